//--- source/rob_pkg.sv
`default_nettype none

package rob_pkg;

    //////////////////////////////////////////////////
    // Buffer geometry and datapath widths
    //////////////////////////////////////////////////

    localparam int ROB_ENTRIES = 8;
    localparam int ROB_ID_W    = $clog2(ROB_ENTRIES);
    localparam int DATA_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int PC_W        = 32;

    // Instruction id, which is also the slot index
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // Exception kind reported at retire
    typedef enum logic [1:0]
    {
        XCPT_NONE   = 2'd0,
        XCPT_FETCH  = 2'd1,
        XCPT_DECODE = 2'd2,
        XCPT_ALU    = 2'd3
    } xcpt_type_t;

    // Writeback request from an execution unit
    typedef struct packed
    {
        rob_id_t                instr_id;
        logic                   rf_wen;
        logic [REG_ADDR_W-1:0]  rf_dest;
        logic [DATA_W-1:0]      rf_data;
        logic [PC_W-1:0]        pc;
        logic                   xcpt_fetch;
        logic                   xcpt_decode;
        logic                   xcpt_alu;
    } wb_req_t;

    // One slot of the buffer, flags already decoded
    typedef struct packed
    {
        rob_id_t                instr_id;
        logic                   rf_wen;
        logic [REG_ADDR_W-1:0]  rf_dest;
        logic [DATA_W-1:0]      rf_data;
        logic [PC_W-1:0]        pc;
        logic                   xcpt_valid;
        xcpt_type_t             xcpt_type;
    } rob_entry_t;

endpackage

`default_nettype wire

//--- source/wb_xcpt_decode.sv
`timescale 1ns/10ps
`default_nettype none

module wb_xcpt_decode
(
    input   rob_pkg::wb_req_t       req,
    output  logic                   xcpt_valid,
    output  rob_pkg::xcpt_type_t    xcpt_type
);

    import rob_pkg::*;

    //////////////////////////////////////////////////
    // Exception flag decode
    //////////////////////////////////////////////////

    // Any raised flag marks the instruction as excepting
    assign xcpt_valid = req.xcpt_fetch | req.xcpt_decode | req.xcpt_alu;

    // Earliest pipeline stage wins when several flags are set
    always_comb
    begin
        if (req.xcpt_fetch)
        begin
            xcpt_type = XCPT_FETCH;
        end
        else if (req.xcpt_decode)
        begin
            xcpt_type = XCPT_DECODE;
        end
        else if (req.xcpt_alu)
        begin
            xcpt_type = XCPT_ALU;
        end
        else
        begin
            xcpt_type = XCPT_NONE;
        end
    end

endmodule

`default_nettype wire

//--- source/rob_retire.sv
`timescale 1ns/10ps
`default_nettype none

module rob_retire
(
    input   logic                                           clock,
    input   logic                                           rst_n,
    input   logic                                           invalidate_buffer,

    // Writebacks and their decoded exceptions
    input   logic                                           alu_req_valid,
    input   rob_pkg::wb_req_t                               alu_req_info,
    input   logic                                           alu_xcpt_valid,
    input   rob_pkg::xcpt_type_t                            alu_xcpt_type,
    input   logic                                           mul_req_valid,
    input   rob_pkg::wb_req_t                               mul_req_info,
    input   logic                                           mul_xcpt_valid,
    input   rob_pkg::xcpt_type_t                            mul_xcpt_type,

    // Retire port toward the register file
    input   logic                                           rf_ready,
    output  logic                                           rf_valid,
    output  logic                                           rf_wen,
    output  logic [rob_pkg::REG_ADDR_W-1:0]                 rf_dest,
    output  logic [rob_pkg::DATA_W-1:0]                     rf_data,
    output  rob_pkg::rob_id_t                               rf_instr_id,
    output  logic                                           xcpt_valid,
    output  rob_pkg::xcpt_type_t                            xcpt_type,
    output  logic [rob_pkg::PC_W-1:0]                       xcpt_pc,

    // Status
    output  logic                                           flush_pipeline,
    output  logic                                           rob_full,

    // Storage view for the bypass
    output  logic [rob_pkg::ROB_ENTRIES-1:0]                entry_valid,
    output  rob_pkg::rob_entry_t [rob_pkg::ROB_ENTRIES-1:0] entries
);

    import rob_pkg::*;

    function automatic rob_entry_t make_entry
    (
        input wb_req_t      req,
        input logic         xv,
        input xcpt_type_t   xt
    );
        rob_entry_t e;
        e.instr_id   = req.instr_id;
        e.rf_wen     = req.rf_wen;
        e.rf_dest    = req.rf_dest;
        e.rf_data    = req.rf_data;
        e.pc         = req.pc;
        e.xcpt_valid = xv;
        e.xcpt_type  = xt;
        return e;
    endfunction

    rob_id_t                    head;
    rob_entry_t                 head_entry;
    logic                       retire_fire;
    logic [ROB_ENTRIES-1:0]     valid_next;
    logic                       flush_set;

    //////////////////////////////////////////////////
    // Writeback capture
    //////////////////////////////////////////////////

    // Each id owns its slot, so both units may write in the same cycle
    always_ff @(posedge clock)
    begin
        if (alu_req_valid)
        begin
            entries[alu_req_info.instr_id] <= make_entry(alu_req_info, alu_xcpt_valid,
                                                         alu_xcpt_type);
        end
        if (mul_req_valid)
        begin
            entries[mul_req_info.instr_id] <= make_entry(mul_req_info, mul_xcpt_valid,
                                                         mul_xcpt_type);
        end
    end

    assign head_entry  = entries[head];
    assign rob_full    = &entry_valid;

    // Head moves only when the output register is free or being drained
    assign retire_fire = entry_valid[head] & (~rf_valid | rf_ready) & ~invalidate_buffer;

    always_comb
    begin
        valid_next = entry_valid;
        if (retire_fire)
        begin
            valid_next[head] = 1'b0;
        end
        if (alu_req_valid)
        begin
            valid_next[alu_req_info.instr_id] = 1'b1;
        end
        if (mul_req_valid)
        begin
            valid_next[mul_req_info.instr_id] = 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            entry_valid <= '0;
            head        <= '0;
        end
        else if (invalidate_buffer)
        begin
            entry_valid <= '0;
            head        <= '0;
        end
        else
        begin
            entry_valid <= valid_next;
            if (retire_fire)
            begin
                head <= head + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Retire output register
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rf_valid <= 1'b0;
        end
        else if (retire_fire)
        begin
            rf_valid <= 1'b1;
        end
        else if (rf_ready)
        begin
            rf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock)
    begin
        if (retire_fire)
        begin
            // Excepting instructions never update the register file
            rf_wen      <= head_entry.rf_wen & ~head_entry.xcpt_valid;
            rf_dest     <= head_entry.rf_dest;
            rf_data     <= head_entry.rf_data;
            rf_instr_id <= head_entry.instr_id;
            xcpt_valid  <= head_entry.xcpt_valid;
            xcpt_type   <= head_entry.xcpt_type;
            xcpt_pc     <= head_entry.pc;
        end
    end

    //////////////////////////////////////////////////
    // Pipeline flush
    //////////////////////////////////////////////////

    assign flush_set = (alu_req_valid & alu_xcpt_valid) | (mul_req_valid & mul_xcpt_valid);

    // A new excepting writeback keeps the flush up over a retiring one
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            flush_pipeline <= 1'b0;
        end
        else if (invalidate_buffer)
        begin
            flush_pipeline <= 1'b0;
        end
        else if (flush_set)
        begin
            flush_pipeline <= 1'b1;
        end
        else if (retire_fire && head_entry.xcpt_valid)
        begin
            flush_pipeline <= 1'b0;
        end
    end

    // Units are issued distinct ids, so they never collide on a slot
    a_distinct_wb_ids: assert property (@(posedge clock) disable iff (!rst_n)
        alu_req_valid && mul_req_valid |-> alu_req_info.instr_id != mul_req_info.instr_id);

    a_stable_under_stall: assert property (@(posedge clock) disable iff (!rst_n)
        rf_valid && !rf_ready |=> rf_valid && $stable({rf_wen, rf_dest, rf_data,
            rf_instr_id, xcpt_valid, xcpt_type, xcpt_pc}));

endmodule

`default_nettype wire

//--- source/rob_bypass.sv
`timescale 1ns/10ps
`default_nettype none

module rob_bypass
(
    input   logic [rob_pkg::ROB_ENTRIES-1:0]                entry_valid,
    input   rob_pkg::rob_entry_t [rob_pkg::ROB_ENTRIES-1:0] entries,

    // Writebacks arriving this cycle
    input   logic                                           alu_req_valid,
    input   rob_pkg::wb_req_t                               alu_req_info,
    input   logic                                           mul_req_valid,
    input   rob_pkg::wb_req_t                               mul_req_info,

    // Operand lookups
    input   rob_pkg::rob_id_t                               alu_src1_id,
    input   rob_pkg::rob_id_t                               alu_src2_id,
    input   rob_pkg::rob_id_t                               mul_src1_id,
    input   rob_pkg::rob_id_t                               mul_src2_id,
    output  logic                                           alu_src1_hit,
    output  logic                                           alu_src2_hit,
    output  logic                                           mul_src1_hit,
    output  logic                                           mul_src2_hit,
    output  logic [rob_pkg::DATA_W-1:0]                     alu_src1_data,
    output  logic [rob_pkg::DATA_W-1:0]                     alu_src2_data,
    output  logic [rob_pkg::DATA_W-1:0]                     mul_src1_data,
    output  logic [rob_pkg::DATA_W-1:0]                     mul_src2_data
);

    import rob_pkg::*;

    // Returns {hit, data}; stored entries first, then ALU, then MUL writeback
    function automatic logic [DATA_W:0] lookup(input rob_id_t id);
        logic [DATA_W:0] res;
        res = '0;
        if (entry_valid[id])
        begin
            res = {1'b1, entries[id].rf_data};
        end
        else if (alu_req_valid && alu_req_info.rf_wen && alu_req_info.instr_id == id)
        begin
            res = {1'b1, alu_req_info.rf_data};
        end
        else if (mul_req_valid && mul_req_info.rf_wen && mul_req_info.instr_id == id)
        begin
            res = {1'b1, mul_req_info.rf_data};
        end
        return res;
    endfunction

    always_comb
    begin
        {alu_src1_hit, alu_src1_data} = lookup(alu_src1_id);
        {alu_src2_hit, alu_src2_data} = lookup(alu_src2_id);
        {mul_src1_hit, mul_src1_data} = lookup(mul_src1_id);
        {mul_src2_hit, mul_src2_data} = lookup(mul_src2_id);
    end

endmodule

`default_nettype wire

//--- source/reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer
(
    input   logic                               clock,
    input   logic                               rst_n,
    input   logic                               invalidate_buffer,
    output  logic                               flush_pipeline,
    output  logic                               rob_full,

    // Writebacks
    input   logic                               alu_req_valid,
    input   rob_pkg::wb_req_t                   alu_req_info,
    input   logic                               mul_req_valid,
    input   rob_pkg::wb_req_t                   mul_req_info,

    // Retire port toward the register file
    input   logic                               rf_ready,
    output  logic                               rf_valid,
    output  logic                               rf_wen,
    output  logic [rob_pkg::REG_ADDR_W-1:0]     rf_dest,
    output  logic [rob_pkg::DATA_W-1:0]         rf_data,
    output  rob_pkg::rob_id_t                   rf_instr_id,
    output  logic                               xcpt_valid,
    output  rob_pkg::xcpt_type_t                xcpt_type,
    output  logic [rob_pkg::PC_W-1:0]           xcpt_pc,

    // Bypass lookups
    input   rob_pkg::rob_id_t                   alu_src1_id,
    input   rob_pkg::rob_id_t                   alu_src2_id,
    input   rob_pkg::rob_id_t                   mul_src1_id,
    input   rob_pkg::rob_id_t                   mul_src2_id,
    output  logic                               alu_src1_hit,
    output  logic                               alu_src2_hit,
    output  logic                               mul_src1_hit,
    output  logic                               mul_src2_hit,
    output  logic [rob_pkg::DATA_W-1:0]         alu_src1_data,
    output  logic [rob_pkg::DATA_W-1:0]         alu_src2_data,
    output  logic [rob_pkg::DATA_W-1:0]         mul_src1_data,
    output  logic [rob_pkg::DATA_W-1:0]         mul_src2_data
);

    import rob_pkg::*;

    logic                               alu_xcpt_valid;
    xcpt_type_t                         alu_xcpt_type;
    logic                               mul_xcpt_valid;
    xcpt_type_t                         mul_xcpt_type;
    logic [ROB_ENTRIES-1:0]             entry_valid;
    rob_entry_t [ROB_ENTRIES-1:0]       entries;

    //////////////////////////////////////////////////
    // Decode, storage and retire, bypass
    //////////////////////////////////////////////////

    wb_xcpt_decode u_alu_xcpt
    (
        .req            (alu_req_info),
        .xcpt_valid     (alu_xcpt_valid),
        .xcpt_type      (alu_xcpt_type)
    );

    wb_xcpt_decode u_mul_xcpt
    (
        .req            (mul_req_info),
        .xcpt_valid     (mul_xcpt_valid),
        .xcpt_type      (mul_xcpt_type)
    );

    rob_retire u_rob_retire
    (
        .clock              (clock),
        .rst_n              (rst_n),
        .invalidate_buffer  (invalidate_buffer),
        .alu_req_valid      (alu_req_valid),
        .alu_req_info       (alu_req_info),
        .alu_xcpt_valid     (alu_xcpt_valid),
        .alu_xcpt_type      (alu_xcpt_type),
        .mul_req_valid      (mul_req_valid),
        .mul_req_info       (mul_req_info),
        .mul_xcpt_valid     (mul_xcpt_valid),
        .mul_xcpt_type      (mul_xcpt_type),
        .rf_ready           (rf_ready),
        .rf_valid           (rf_valid),
        .rf_wen             (rf_wen),
        .rf_dest            (rf_dest),
        .rf_data            (rf_data),
        .rf_instr_id        (rf_instr_id),
        .xcpt_valid         (xcpt_valid),
        .xcpt_type          (xcpt_type),
        .xcpt_pc            (xcpt_pc),
        .flush_pipeline     (flush_pipeline),
        .rob_full           (rob_full),
        .entry_valid        (entry_valid),
        .entries            (entries)
    );

    rob_bypass u_rob_bypass
    (
        .entry_valid    (entry_valid),
        .entries        (entries),
        .alu_req_valid  (alu_req_valid),
        .alu_req_info   (alu_req_info),
        .mul_req_valid  (mul_req_valid),
        .mul_req_info   (mul_req_info),
        .alu_src1_id    (alu_src1_id),
        .alu_src2_id    (alu_src2_id),
        .mul_src1_id    (mul_src1_id),
        .mul_src2_id    (mul_src2_id),
        .alu_src1_hit   (alu_src1_hit),
        .alu_src2_hit   (alu_src2_hit),
        .mul_src1_hit   (mul_src1_hit),
        .mul_src2_hit   (mul_src2_hit),
        .alu_src1_data  (alu_src1_data),
        .alu_src2_data  (alu_src2_data),
        .mul_src1_data  (mul_src1_data),
        .mul_src2_data  (mul_src2_data)
    );

endmodule

`default_nettype wire

//--- verif/tb_reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module tb_reorder_buffer;

    import rob_pkg::*;

    typedef struct packed
    {
        logic           unit;   // 0 ALU, 1 MUL
        rob_id_t        id;
        logic [31:0]    data;
        logic [4:0]     dest;
        logic           wen;
        logic [2:0]     flags;  // {fetch, decode, alu}
        int             gap;
    } row_t;

    typedef struct packed
    {
        rob_id_t        id;
        logic           wen;
        logic [4:0]     dest;
        logic [31:0]    data;
        logic           xv;
        xcpt_type_t     xt;
        logic [31:0]    pc;
    } exp_t;

    localparam int NUM_ROWS  = 8;
    localparam int MAX_CYCLE = NUM_ROWS * 8 + 100;

    logic clock, rst_n, invalidate_buffer, flush_pipeline, rob_full;
    logic alu_req_valid, mul_req_valid;
    wb_req_t alu_req_info, mul_req_info;
    logic rf_ready, rf_valid, rf_wen, xcpt_valid;
    logic [REG_ADDR_W-1:0] rf_dest;
    logic [DATA_W-1:0] rf_data;
    rob_id_t rf_instr_id;
    xcpt_type_t xcpt_type;
    logic [PC_W-1:0] xcpt_pc;
    rob_id_t alu_src1_id, alu_src2_id, mul_src1_id, mul_src2_id;
    logic alu_src1_hit, alu_src2_hit, mul_src1_hit, mul_src2_hit;
    logic [DATA_W-1:0] alu_src1_data, alu_src2_data, mul_src1_data, mul_src2_data;

    row_t   rows [NUM_ROWS];
    exp_t   expect_q [$];
    int     seed = 32'h70a2f248;
    int     rnd;
    int     cycles = 0;
    logic   rand_ready = 1'b0;
    logic   held = 1'b0;
    logic [11:0] held_small;
    logic [31:0] held_data;
    logic [31:0] held_pc;

    reorder_buffer i_dut (.*);

    always #10 clock = ~clock;

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp)
        begin
            $display("[FAIL] %0t: %s got %h expected %h", $time, msg, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] pc_of(input rob_id_t id);
        return 32'h0000_1000 + 32'(id) * 32'd4;
    endfunction

    // Fetch beats decode beats ALU
    function automatic xcpt_type_t expected_type(input logic [2:0] flags);
        if (flags[2])
            return XCPT_FETCH;
        else if (flags[1])
            return XCPT_DECODE;
        else if (flags[0])
            return XCPT_ALU;
        return XCPT_NONE;
    endfunction

    task automatic push_expect(input rob_id_t id, input logic [31:0] data,
                               input logic [4:0] dest, input logic wen, input logic [2:0] flags);
        exp_t e;
        e.id   = id;
        e.xv   = |flags;
        e.wen  = wen & ~e.xv;
        e.dest = dest;
        e.data = data;
        e.xt   = expected_type(flags);
        e.pc   = pc_of(id);
        expect_q.push_back(e);
    endtask

    task automatic set_wb(input logic unit, input rob_id_t id, input logic [31:0] data,
                          input logic [4:0] dest, input logic wen, input logic [2:0] flags);
        wb_req_t req;
        req.instr_id = id;
        req.rf_wen   = wen;
        req.rf_dest  = dest;
        req.rf_data  = data;
        req.pc       = pc_of(id);
        {req.xcpt_fetch, req.xcpt_decode, req.xcpt_alu} = flags;
        if (unit)
        begin
            mul_req_valid <= 1'b1;
            mul_req_info  <= req;
        end
        else
        begin
            alu_req_valid <= 1'b1;
            alu_req_info  <= req;
        end
    endtask

    // Retirements are popped on the falling edge, so poll on the rising one
    task automatic wait_drained();
        while (expect_q.size() != 0)
            @(posedge clock);
        @(negedge clock);
    endtask

    //////////////////////////////////////////////////
    // Back-pressure, scoreboard and timeout
    //////////////////////////////////////////////////

    always @(posedge clock)
    begin
        if (rand_ready)
        begin
            rnd = $random(seed);
            rf_ready <= rnd[0];
        end
    end

    always @(negedge clock)
    begin
        exp_t e;
        if (held)
        begin
            check(64'(rf_valid), 64'd1, "rf_valid dropped under stall");
            check(64'({rf_wen, rf_dest, rf_instr_id, xcpt_valid, xcpt_type}),
                  64'(held_small), "control fields moved under stall");
            check(64'(rf_data), 64'(held_data), "rf_data moved under stall");
            check(64'(xcpt_pc), 64'(held_pc), "xcpt_pc moved under stall");
        end
        held       = rst_n && rf_valid && !rf_ready;
        held_small = {rf_wen, rf_dest, rf_instr_id, xcpt_valid, xcpt_type};
        held_data  = rf_data;
        held_pc    = xcpt_pc;
        if (rst_n && rf_valid && rf_ready)
        begin
            if (expect_q.size() == 0)
            begin
                $display("Unexpected retirement of id %0d at %0t", rf_instr_id, $time);
                $display("test failed");
                $fatal(1);
            end
            e = expect_q.pop_front();
            check(64'(rf_instr_id), 64'(e.id), "rf_instr_id");
            check(64'(rf_wen), 64'(e.wen), "rf_wen");
            check(64'(rf_dest), 64'(e.dest), "rf_dest");
            check(64'(rf_data), 64'(e.data), "rf_data");
            check(64'(xcpt_valid), 64'(e.xv), "xcpt_valid");
            check(64'(xcpt_type), 64'(e.xt), "xcpt_type");
            if (e.xv)
                check(64'(xcpt_pc), 64'(e.pc), "xcpt_pc");
        end
    end

    always @(posedge clock)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLE)
        begin
            $display("Timeout after %0d cycles with %0d retirements outstanding",
                     cycles, expect_q.size());
            $display("test failed");
            $fatal(1);
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial
    begin
        clock = 1'b0;
        rst_n = 1'b0;
        invalidate_buffer = 1'b0;
        alu_req_valid = 1'b0;
        mul_req_valid = 1'b0;
        alu_req_info = '0;
        mul_req_info = '0;
        rf_ready = 1'b0;
        alu_src1_id = '0;
        alu_src2_id = '0;
        mul_src1_id = '0;
        mul_src2_id = '0;

        // Out of order over both units, a few with exception flags
        rows[0] = '{1'b0, 3'd3, 32'h0000_3333, 5'd3, 1'b1, 3'b000, 1};
        rows[1] = '{1'b1, 3'd1, 32'h0000_1111, 5'd1, 1'b1, 3'b000, 0};
        rows[2] = '{1'b0, 3'd0, 32'h0000_0f0f, 5'd7, 1'b1, 3'b000, 2};
        rows[3] = '{1'b1, 3'd5, 32'h0000_5555, 5'd5, 1'b1, 3'b011, 0};
        rows[4] = '{1'b0, 3'd2, 32'h0000_2222, 5'd2, 1'b0, 3'b000, 1};
        rows[5] = '{1'b1, 3'd7, 32'h0000_7777, 5'd9, 1'b1, 3'b001, 0};
        rows[6] = '{1'b0, 3'd6, 32'h0000_6666, 5'd6, 1'b1, 3'b101, 1};
        rows[7] = '{1'b1, 3'd4, 32'h0000_4444, 5'd4, 1'b1, 3'b000, 0};

        // Retirement follows id order no matter the arrival order
        for (int id = 0; id < NUM_ROWS; id++)
            for (int r = 0; r < NUM_ROWS; r++)
                if (rows[r].id == rob_id_t'(id))
                    push_expect(rows[r].id, rows[r].data, rows[r].dest, rows[r].wen,
                                rows[r].flags);

        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check(64'(rf_valid), 64'd0, "rf_valid after reset");
        check(64'(flush_pipeline), 64'd0, "flush_pipeline after reset");
        check(64'(rob_full), 64'd0, "rob_full after reset");
        rand_ready = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            @(posedge clock);
            set_wb(rows[r].unit, rows[r].id, rows[r].data, rows[r].dest, rows[r].wen,
                   rows[r].flags);
            @(posedge clock);
            alu_req_valid <= 1'b0;
            mul_req_valid <= 1'b0;
            @(negedge clock);
            if (rows[r].flags != 3'b000)
                check(64'(flush_pipeline), 64'd1, "flush_pipeline after excepting writeback");
            repeat (rows[r].gap) @(posedge clock);
        end
        wait_drained();
        check(64'(flush_pipeline), 64'd0, "flush_pipeline after excepting entries retired");
        rand_ready = 1'b0;
        @(posedge clock);
        rf_ready <= 1'b0;

        // Id 0 parks in the output register while the register file stalls
        push_expect(3'd0, 32'h0000_00a0, 5'd10, 1'b1, 3'b000);
        set_wb(1'b0, 3'd0, 32'h0000_00a0, 5'd10, 1'b1, 3'b000);
        @(posedge clock);
        alu_req_valid <= 1'b0;
        while (!rf_valid)
            @(negedge clock);

        // Same-cycle bypass
        @(posedge clock);
        set_wb(1'b0, 3'd2, 32'hd2d2_0002, 5'd2, 1'b1, 3'b000);
        set_wb(1'b1, 3'd3, 32'hd3d3_0003, 5'd3, 1'b0, 3'b000);
        alu_src1_id <= 3'd2;
        alu_src2_id <= 3'd3;
        mul_src1_id <= 3'd4;
        mul_src2_id <= 3'd0;
        @(negedge clock);
        check(64'({alu_src1_hit, alu_src1_data}), {31'd0, 1'b1, 32'hd2d2_0002}, "alu bypass");
        check(64'(alu_src2_hit), 64'd0, "bypass of writeback without rf_wen");
        check(64'(mul_src1_hit), 64'd0, "bypass of absent id");
        check(64'(mul_src2_hit), 64'd0, "bypass of retired id");

        // Stored entry and MUL same-cycle bypass
        @(posedge clock);
        alu_req_valid <= 1'b0;
        set_wb(1'b1, 3'd4, 32'hd4d4_0004, 5'd4, 1'b1, 3'b000);
        alu_src1_id <= 3'd5;
        alu_src2_id <= 3'd2;
        mul_src1_id <= 3'd4;
        mul_src2_id <= 3'd2;
        @(negedge clock);
        check(64'({mul_src1_hit, mul_src1_data}), {31'd0, 1'b1, 32'hd4d4_0004}, "mul bypass");
        check(64'({alu_src2_hit, alu_src2_data}), {31'd0, 1'b1, 32'hd2d2_0002},
              "stored entry bypass on alu");
        check(64'({mul_src2_hit, mul_src2_data}), {31'd0, 1'b1, 32'hd2d2_0002},
              "stored entry bypass on mul");
        check(64'(alu_src1_hit), 64'd0, "bypass of empty slot");
        check(64'(rob_full), 64'd0, "rob_full with free slots");

        // Fill the remaining slots
        for (int id = 0; id < 5; id++)
        begin
            @(posedge clock);
            mul_req_valid <= 1'b0;
            set_wb(1'b0, (id == 0) ? 3'd1 : (id == 4) ? 3'd0 : rob_id_t'(id + 4),
                   32'h0000_0bad, 5'd1, 1'b1, 3'b000);
        end
        @(posedge clock);
        alu_req_valid <= 1'b0;
        @(negedge clock);
        check(64'(rob_full), 64'd1, "rob_full with all slots valid");

        @(posedge clock);
        invalidate_buffer <= 1'b1;
        @(posedge clock);
        invalidate_buffer <= 1'b0;
        @(negedge clock);
        check(64'(rob_full), 64'd0, "rob_full after invalidate");
        check(64'(rf_valid), 64'd1, "output register kept by invalidate");

        // Head restarts at id 0
        push_expect(3'd0, 32'h0000_c000, 5'd12, 1'b1, 3'b000);
        push_expect(3'd1, 32'h0000_c001, 5'd13, 1'b1, 3'b000);
        @(posedge clock);
        rf_ready <= 1'b1;
        set_wb(1'b1, 3'd1, 32'h0000_c001, 5'd13, 1'b1, 3'b000);
        @(posedge clock);
        mul_req_valid <= 1'b0;
        set_wb(1'b0, 3'd0, 32'h0000_c000, 5'd12, 1'b1, 3'b000);
        @(posedge clock);
        alu_req_valid <= 1'b0;
        wait_drained();

        // Idle a few cycles so a duplicate retirement would still show up
        repeat (3) @(negedge clock);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
source/rob_pkg.sv
source/wb_xcpt_decode.sv
source/rob_retire.sv
source/rob_bypass.sv
source/reorder_buffer.sv
verif/tb_reorder_buffer.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_reorder_buffer
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
